//--- hdl/sd_cmd_pkg.sv
package sd_cmd_pkg;

	// frame geometry on the CMD line
	localparam int FRAME_BITS = 48;
	localparam int CMD_BITS = 40;
	localparam int NCR_TIMEOUT = 64; // cycles allowed for the start bit
	localparam int COUNT_WIDTH = 7;

	// crc field left at zero before the end bit
	localparam logic [FRAME_BITS-CMD_BITS-1:0] CMD_TRAILER = 8'b0000_0001;

	// command and response share this 40-bit layout
	typedef struct packed
	{
		logic start_bit;
		logic transmission_bit;
		logic [5:0] index;
		logic [31:0] argument;
	} sd_command_t;

	typedef enum logic [3:0]
	{
		ST_RESET,
		ST_IDLE,
		ST_LOAD_COMMAND,
		ST_SEND_COMMAND,
		ST_WAIT_RESPONSE,
		ST_RECEIVE_RESPONSE,
		ST_SEND_RESPONSE,
		ST_WAIT_ACK
	} cmd_state_t;

	typedef enum logic [1:0]
	{
		CNT_HOLD,
		CNT_LOAD_FRAME,
		CNT_LOAD_TIMEOUT,
		CNT_DEC
	} cnt_op_t;

endpackage

//--- hdl/cmd_phys_controller.sv
`timescale 1ns/10ps

module cmd_phys_controller import sd_cmd_pkg::*;
(
	input logic sd_clock,
	input logic reset,
	input logic strobe_in,
	input logic ack_in,
	input logic idle_in,
	input sd_command_t cmd_to_send,
	input logic count_done,
	input logic start_seen,
	input logic [FRAME_BITS-1:0] rx_frame,
	output logic ack_out,
	output logic strobe_out,
	output sd_command_t response,
	output logic response_timeout,
	output cnt_op_t cnt_op,
	output logic load,
	output logic shift_en,
	output logic rx_en,
	output logic cmd_oe,
	output logic [FRAME_BITS-1:0] tx_frame
);

	cmd_state_t state;
	cmd_state_t next_state;
	sd_command_t cmd_reg;

	// command held for the whole transfer as the host strobe lasts one cycle
	always_ff @(posedge sd_clock)
	begin
		if (state == ST_IDLE && strobe_in)
		begin
			cmd_reg <= cmd_to_send;
		end
	end

	assign tx_frame = {cmd_reg, CMD_TRAILER};

	always_comb
	begin
		next_state = state;
		case (state)
			ST_RESET:
				next_state = ST_IDLE;
			ST_IDLE:
				if (strobe_in)
				begin
					next_state = ST_LOAD_COMMAND;
				end
			ST_LOAD_COMMAND:
				next_state = ST_SEND_COMMAND;
			ST_SEND_COMMAND:
				if (count_done) // last bit on the line
				begin
					next_state = ST_WAIT_RESPONSE;
				end
			ST_WAIT_RESPONSE:
				if (start_seen)
				begin
					next_state = ST_RECEIVE_RESPONSE;
				end
				else if (count_done) // NCR expired
				begin
					next_state = ST_SEND_RESPONSE;
				end
			ST_RECEIVE_RESPONSE:
				if (count_done)
				begin
					next_state = ST_SEND_RESPONSE;
				end
			ST_SEND_RESPONSE:
				next_state = ST_WAIT_ACK;
			ST_WAIT_ACK:
				if (ack_in)
				begin
					next_state = ST_IDLE;
				end
			default:
				next_state = ST_RESET;
		endcase
	end

	// counter is reused as bit counter and NCR timer
	always_comb
	begin
		cnt_op = CNT_HOLD;
		case (state)
			ST_LOAD_COMMAND:
				cnt_op = CNT_LOAD_FRAME;
			ST_SEND_COMMAND:
				cnt_op = count_done ? CNT_LOAD_TIMEOUT : CNT_DEC;
			ST_WAIT_RESPONSE:
				if (start_seen)
				begin
					cnt_op = CNT_LOAD_FRAME; // start bit counts as bit 47
				end
				else if (!count_done)
				begin
					cnt_op = CNT_DEC;
				end
			ST_RECEIVE_RESPONSE:
				if (!count_done)
				begin
					cnt_op = CNT_DEC;
				end
			default:
				cnt_op = CNT_HOLD;
		endcase
	end

	assign load = (state == ST_LOAD_COMMAND);
	assign shift_en = (state == ST_SEND_COMMAND);
	assign cmd_oe = (state == ST_SEND_COMMAND);
	// stop sampling once all 48 bits are in
	assign rx_en = (state == ST_WAIT_RESPONSE) ||
		(state == ST_RECEIVE_RESPONSE && !count_done);
	assign strobe_out = (state == ST_SEND_RESPONSE);
	assign ack_out = (state == ST_WAIT_ACK) && ack_in;

	always_ff @(posedge sd_clock)
	begin
		if (state == ST_RECEIVE_RESPONSE && count_done)
		begin
			response <= rx_frame[FRAME_BITS-1 -: CMD_BITS]; // drop the trailer byte
			response_timeout <= 1'b0;
		end
		else if (state == ST_WAIT_RESPONSE && !start_seen && count_done)
		begin
			response <= '0;
			response_timeout <= 1'b1;
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			state <= ST_RESET;
		end
		else if (idle_in)
		begin
			state <= ST_IDLE; // abort from any state
		end
		else
		begin
			state <= next_state;
		end
	end

endmodule

//--- hdl/cmd_bit_counter.sv
`timescale 1ns/10ps

module cmd_bit_counter import sd_cmd_pkg::*;
(
	input logic sd_clock,
	input logic reset,
	input cnt_op_t cnt_op,
	output logic count_done
);

	logic [COUNT_WIDTH-1:0] count;

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			count <= '0;
		end
		else
		begin
			case (cnt_op)
				CNT_LOAD_FRAME:
					count <= COUNT_WIDTH'(FRAME_BITS - 1);
				CNT_LOAD_TIMEOUT:
					count <= COUNT_WIDTH'(NCR_TIMEOUT);
				CNT_DEC:
					count <= count - 1'b1;
				default:
					count <= count; // hold
			endcase
		end
	end

	// meaning depends on the controller state
	assign count_done = (count == '0);

endmodule

//--- hdl/cmd_serializer.sv
`timescale 1ns/10ps

module cmd_serializer import sd_cmd_pkg::*;
(
	input logic sd_clock,
	input logic reset,
	input logic load,
	input logic shift_en,
	input logic [FRAME_BITS-1:0] tx_frame,
	output logic cmd_out
);

	logic [FRAME_BITS-1:0] shift_reg;

	// ones fill in behind the frame so the line rests high
	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			shift_reg <= '1;
		end
		else if (load)
		begin
			shift_reg <= tx_frame;
		end
		else if (shift_en)
		begin
			shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b1};
		end
	end

	assign cmd_out = shift_reg[FRAME_BITS-1]; // msb first

endmodule

//--- hdl/cmd_deserializer.sv
`timescale 1ns/10ps

module cmd_deserializer import sd_cmd_pkg::*;
(
	input logic sd_clock,
	input logic reset,
	input logic rx_en,
	input logic cmd_in,
	output logic start_seen,
	output logic [FRAME_BITS-1:0] rx_frame
);

	logic started;

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			started <= 1'b0;
		end
		else if (!rx_en)
		begin
			started <= 1'b0;
		end
		else if (!cmd_in)
		begin
			started <= 1'b1; // first low is the start bit
		end
	end

	// high already in the start bit cycle, so the start bit itself is captured
	assign start_seen = rx_en && (started || !cmd_in);

	always_ff @(posedge sd_clock)
	begin
		if (start_seen)
		begin
			rx_frame <= {rx_frame[FRAME_BITS-2:0], cmd_in};
		end
	end

endmodule

//--- hdl/sd_cmd_phy.sv
`timescale 1ns/10ps

module sd_cmd_phy import sd_cmd_pkg::*;
(
	input logic sd_clock,
	input logic reset,
	input logic strobe_in,
	input logic ack_in,
	input logic idle_in,
	input sd_command_t cmd_to_send,
	input logic cmd_in,
	output logic ack_out,
	output logic strobe_out,
	output sd_command_t response,
	output logic response_timeout,
	output logic cmd_out,
	output logic cmd_oe
);

	cnt_op_t cnt_op;
	logic count_done;
	logic load;
	logic shift_en;
	logic rx_en;
	logic start_seen;
	logic [FRAME_BITS-1:0] tx_frame;
	logic [FRAME_BITS-1:0] rx_frame;

	cmd_phys_controller controller
	(
		.sd_clock(sd_clock),
		.reset(reset),
		.strobe_in(strobe_in),
		.ack_in(ack_in),
		.idle_in(idle_in),
		.cmd_to_send(cmd_to_send),
		.count_done(count_done),
		.start_seen(start_seen),
		.rx_frame(rx_frame),
		.ack_out(ack_out),
		.strobe_out(strobe_out),
		.response(response),
		.response_timeout(response_timeout),
		.cnt_op(cnt_op),
		.load(load),
		.shift_en(shift_en),
		.rx_en(rx_en),
		.cmd_oe(cmd_oe),
		.tx_frame(tx_frame)
	);

	cmd_bit_counter counter
	(
		.sd_clock(sd_clock),
		.reset(reset),
		.cnt_op(cnt_op),
		.count_done(count_done)
	);

	cmd_serializer serializer
	(
		.sd_clock(sd_clock),
		.reset(reset),
		.load(load),
		.shift_en(shift_en),
		.tx_frame(tx_frame),
		.cmd_out(cmd_out)
	);

	cmd_deserializer deserializer
	(
		.sd_clock(sd_clock),
		.reset(reset),
		.rx_en(rx_en),
		.cmd_in(cmd_in),
		.start_seen(start_seen),
		.rx_frame(rx_frame)
	);

endmodule

//--- test/sd_cmd_tb_tasks.svh
logic card_silent;
int card_delay; // cycles from cmd_oe fall to start bit
logic [FRAME_BITS-1:0] card_response;
logic [FRAME_BITS-1:0] card_shift;
int card_count;
logic [FRAME_BITS-1:0] host_frame; // last frame seen by the card
int host_bits;
int frames_seen;

task automatic drive_response();
	int i;
	repeat (card_delay) @(negedge sd_clock);
	for (i = FRAME_BITS - 1; i >= 0; i--)
	begin
		cmd_in = card_response[i];
		@(negedge sd_clock);
	end
	cmd_in = 1'b1; // pulled up again
endtask

// card side of the CMD line
initial
begin
	cmd_in = 1'b1;
	card_silent = 1'b0;
	card_delay = 2;
	card_response = '1;
	card_shift = '0;
	card_count = 0;
	host_frame = '0;
	host_bits = 0;
	frames_seen = 0;
	forever
	begin
		@(negedge sd_clock);
		if (cmd_oe === 1'b1)
		begin
			card_shift = {card_shift[FRAME_BITS-2:0], cmd_out};
			card_count++;
		end
		else if (card_count > 0)
		begin
			host_frame = card_shift;
			host_bits = card_count;
			frames_seen++;
			card_count = 0;
			if (host_bits == FRAME_BITS && !card_silent) // cut frames get no answer
			begin
				drive_response();
			end
		end
	end
end

task automatic compare_value(input string name, input logic [63:0] expected,
	input logic [63:0] actual);
	check_count++;
	assert (actual === expected)
	else
	begin
		mismatch_count++;
		$display("mismatch %s: expected 0x%0h, actual 0x%0h at %0t ns",
			name, expected, actual, $time);
	end
endtask

task automatic confirm(input logic condition, input string what);
	check_count++;
	assert (condition === 1'b1)
	else
	begin
		failure_count++;
		$display("error at %0t ns: %s", $time, what);
	end
endtask

function automatic sd_command_t random_command();
	sd_command_t cmd;
	logic [31:0] rand_word;
	rand_word = $random(seed);
	cmd.start_bit = 1'b0;
	cmd.transmission_bit = 1'b1; // host to card
	cmd.index = rand_word[5:0];
	cmd.argument = $random(seed);
	return cmd;
endfunction

// loads the card model with a random answer and delay
task automatic prepare_response(output sd_command_t payload);
	logic [31:0] rand_word;
	rand_word = $random(seed);
	payload.start_bit = 1'b0;
	payload.transmission_bit = 1'b0;
	payload.index = rand_word[5:0];
	payload.argument = $random(seed);
	card_response = {payload, rand_word[14:8], 1'b1}; // random crc field and the end bit
	rand_word = $random(seed);
	card_delay = 2 + rand_word % 39;
	card_silent = 1'b0;
endtask

task automatic issue_command(input sd_command_t cmd);
	@(negedge sd_clock);
	cmd_to_send = cmd;
	strobe_in = 1'b1;
	@(negedge sd_clock);
	strobe_in = 1'b0;
endtask

// busy_strobe_cycle >= 0 pulses strobe_in again in that frame bit
task automatic await_frame(input sd_command_t cmd, input int busy_strobe_cycle);
	int wait_cycles;
	int oe_cycles;
	wait_cycles = 0;
	while (cmd_oe !== 1'b1 && wait_cycles < 8)
	begin
		@(negedge sd_clock);
		wait_cycles++;
	end
	confirm(cmd_oe === 1'b1, "no frame started on the CMD line after strobe_in");
	if (busy_strobe_cycle >= 0)
	begin
		cmd_to_send = sd_command_t'(~cmd);
	end
	oe_cycles = 0;
	while (cmd_oe === 1'b1 && oe_cycles < FRAME_BITS + 8)
	begin
		strobe_in = (oe_cycles == busy_strobe_cycle);
		@(negedge sd_clock);
		oe_cycles++;
	end
	strobe_in = 1'b0;
	compare_value("cmd_oe high cycles", FRAME_BITS, oe_cycles);
	@(negedge sd_clock); // card model stores the frame when cmd_oe falls
	compare_value("cmd_out frame", {cmd, 7'b0000000, 1'b1}, host_frame);
endtask

task automatic await_report(input sd_command_t expected, input logic timed_out,
	input int limit);
	int cycles;
	cycles = 0;
	while (strobe_out !== 1'b1 && cycles < limit)
	begin
		@(negedge sd_clock);
		cycles++;
	end
	confirm(strobe_out === 1'b1, "strobe_out did not arrive in time");
	compare_value("response", expected, response);
	compare_value("response_timeout", timed_out, response_timeout);
	@(negedge sd_clock);
	confirm(strobe_out === 1'b0, "strobe_out stayed high for more than one cycle");
endtask

task automatic acknowledge(input int hold_cycles);
	int i;
	for (i = 0; i < hold_cycles; i++)
	begin
		compare_value("ack_out", 1'b0, ack_out);
		@(negedge sd_clock);
	end
	ack_in = 1'b1;
	#2;
	compare_value("ack_out", 1'b1, ack_out);
	@(negedge sd_clock);
	compare_value("ack_out", 1'b0, ack_out); // back in idle
	ack_in = 1'b0;
endtask

task automatic complete_transfer(input int busy_strobe_cycle, input int ack_wait);
	sd_command_t cmd;
	sd_command_t payload;
	cmd = random_command();
	prepare_response(payload);
	issue_command(cmd);
	await_frame(cmd, busy_strobe_cycle);
	await_report(payload, 1'b0, REPORT_LIMIT);
	acknowledge(ack_wait);
endtask

task automatic frame_after_reset();
	@(negedge sd_clock);
	compare_value("strobe_out", 1'b0, strobe_out);
	compare_value("ack_out", 1'b0, ack_out);
	compare_value("cmd_oe", 1'b0, cmd_oe);
	compare_value("cmd_out", 1'b1, cmd_out);
	complete_transfer(-1, 0);
endtask

task automatic random_responses(input int count);
	int i;
	for (i = 0; i < count; i++)
	begin
		complete_transfer(-1, i % 3);
	end
endtask

task automatic silent_card_timeout();
	sd_command_t cmd;
	cmd = random_command();
	card_silent = 1'b1;
	issue_command(cmd);
	await_frame(cmd, -1);
	await_report('0, 1'b1, NCR_TIMEOUT + 4); // counted from cmd_oe fall
	acknowledge(1);
	card_silent = 1'b0;
endtask

task automatic ack_handshake();
	int frames_before;
	frames_before = frames_seen;
	complete_transfer(20, 4);
	repeat (4)
	begin
		@(negedge sd_clock);
		compare_value("cmd_oe", 1'b0, cmd_oe);
	end
	confirm(frames_seen == frames_before + 1, "strobe_in while busy started a second frame");
	complete_transfer(-1, 0);
endtask

task automatic idle_abort();
	int cycles;
	logic strobe_seen;
	issue_command(random_command());
	cycles = 0;
	while (cmd_oe !== 1'b1 && cycles < 8)
	begin
		@(negedge sd_clock);
		cycles++;
	end
	confirm(cmd_oe === 1'b1, "no frame started before the abort");
	repeat (12) @(negedge sd_clock);
	idle_in = 1'b1;
	@(negedge sd_clock);
	compare_value("cmd_oe", 1'b0, cmd_oe);
	idle_in = 1'b0;
	strobe_seen = 1'b0;
	for (cycles = 0; cycles < NCR_TIMEOUT + 16; cycles++)
	begin
		@(negedge sd_clock);
		strobe_seen = strobe_seen | (strobe_out === 1'b1);
	end
	confirm(!strobe_seen, "strobe_out pulsed after idle_in aborted the command");
	complete_transfer(-1, 0);
endtask

//--- test/sd_cmd_phy_tb.sv
`timescale 1ns/10ps

module sd_cmd_phy_tb import sd_cmd_pkg::*;
();

	localparam int CLOCK_PERIOD = 20;
	localparam int TRANSFER_COUNT = 10; // command transfers over all tests
	localparam int TRANSFER_CYCLES = 2 + FRAME_BITS + NCR_TIMEOUT + FRAME_BITS + 20;
	localparam int WATCHDOG_CYCLES = TRANSFER_COUNT * TRANSFER_CYCLES + 200;
	localparam int REPORT_LIMIT = 40 + FRAME_BITS + 16; // longest card delay plus response

	logic sd_clock;
	logic reset;
	logic strobe_in;
	logic ack_in;
	logic idle_in;
	sd_command_t cmd_to_send;
	logic cmd_in;
	logic ack_out;
	logic strobe_out;
	sd_command_t response;
	logic response_timeout;
	logic cmd_out;
	logic cmd_oe;

	integer seed;
	int check_count;
	int mismatch_count;
	int failure_count;

	sd_cmd_phy UUT
	(
		.sd_clock(sd_clock),
		.reset(reset),
		.strobe_in(strobe_in),
		.ack_in(ack_in),
		.idle_in(idle_in),
		.cmd_to_send(cmd_to_send),
		.cmd_in(cmd_in),
		.ack_out(ack_out),
		.strobe_out(strobe_out),
		.response(response),
		.response_timeout(response_timeout),
		.cmd_out(cmd_out),
		.cmd_oe(cmd_oe)
	);

	`include "sd_cmd_tb_tasks.svh"

	initial
	begin
		sd_clock = 1'b0;
		forever
		begin
			#(CLOCK_PERIOD / 2) sd_clock = ~sd_clock;
		end
	end

	task automatic print_counts();
		$display("checks %0d, mismatches %0d, other errors %0d",
			check_count, mismatch_count, failure_count);
	endtask

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge sd_clock);
		failure_count++;
		$display("watchdog expired after %0d cycles, test sequence did not finish",
			WATCHDOG_CYCLES);
		print_counts();
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		seed = 87;
		check_count = 0;
		mismatch_count = 0;
		failure_count = 0;
		reset = 1'b1;
		strobe_in = 1'b0;
		ack_in = 1'b0;
		idle_in = 1'b0;
		cmd_to_send = '0;
		repeat (3) @(negedge sd_clock);
		reset = 1'b0;

		frame_after_reset();
		random_responses(4);
		silent_card_timeout();
		ack_handshake();
		idle_abort();

		repeat (4) @(negedge sd_clock);
		print_counts();
		if (mismatch_count == 0 && failure_count == 0)
		begin
			$display("TEST PASSED");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+test
hdl/sd_cmd_pkg.sv
hdl/cmd_phys_controller.sv
hdl/cmd_bit_counter.sv
hdl/cmd_serializer.sv
hdl/cmd_deserializer.sv
hdl/sd_cmd_phy.sv
test/sd_cmd_phy_tb.sv
